/* files.f */
rtl/geometryPkg.sv
rtl/attackPkg.sv
rtl/attackDecoder.sv
rtl/attackTimer.sv
rtl/hitboxGenerator.sv
rtl/boxCollision.sv
rtl/strikeResolver.sv
rtl/attackCoprocessor.sv
testbench/attackCoprocessorTb.sv

/* rtl/attackCoprocessor.sv */
`timescale 1ns/10ps

module attackCoprocessor #(
	parameter int smashFrames = 6,
	parameter int jabFrames = 3,
	parameter int specialFrames = 8
) (
	input logic clock,
	input logic arstN,
	input logic frameValid,
	output logic frameReady,
	input geometryPkg::pointT char1Pos,
	input geometryPkg::pointT char1Size,
	input geometryPkg::pointT char2Pos,
	input geometryPkg::pointT char2Size,
	input attackPkg::controlT controls,
	output logic resultValid,
	input logic resultReady,
	output attackPkg::attackWordT attack,
	output geometryPkg::pointT knockback,
	output geometryPkg::pointT movement
);
	import geometryPkg::*;
	import attackPkg::*;

	logic frameTaken;
	logic boxValid;
	logic boxReady;
	attackKindT requestKind;
	attackKindT activeKind;
	pointT hitPos [numBoxes];
	pointT hitSize;
	pointT targetPos;
	pointT targetSize;
	logic [numBoxes-1:0] hit;

	attackDecoder decoder_i (
		.controls(controls),
		.requestKind(requestKind)
	);

	attackTimer #(
		.smashFrames(smashFrames),
		.jabFrames(jabFrames),
		.specialFrames(specialFrames)
	) timer_i (
		.clock(clock),
		.arstN(arstN),
		.frameTaken(frameTaken),
		.requestKind(requestKind),
		.activeKind(activeKind)
	);

	hitboxGenerator hitbox_i (
		.clock(clock),
		.arstN(arstN),
		.frameValid(frameValid),
		.frameReady(frameReady),
		.char1Pos(char1Pos),
		.char1Size(char1Size),
		.char2Pos(char2Pos),
		.char2Size(char2Size),
		.frameTaken(frameTaken),
		.boxValid(boxValid),
		.boxReady(boxReady),
		.hitPos(hitPos),
		.hitSize(hitSize),
		.targetPos(targetPos),
		.targetSize(targetSize)
	);

	// One collision unit per direction
	for (genvar i = int'(dirLeft); i <= int'(dirDown); i++) begin : genCollision
		boxCollision collision_i (
			.boxPos(hitPos[i]),
			.boxSize(hitSize),
			.targetPos(targetPos),
			.targetSize(targetSize),
			.hit(hit[i])
		);
	end

	strikeResolver resolver_i (
		.clock(clock),
		.arstN(arstN),
		.boxValid(boxValid),
		.boxReady(boxReady),
		.hit(hit),
		.activeKind(activeKind),
		.resultValid(resultValid),
		.resultReady(resultReady),
		.attack(attack),
		.knockback(knockback),
		.movement(movement)
	);

endmodule

/* rtl/attackDecoder.sv */
`timescale 1ns/10ps

module attackDecoder (
	input attackPkg::controlT controls,
	output attackPkg::attackKindT requestKind
);
	import attackPkg::*;

	logic stickLeft;
	logic stickRight;
	logic stickUp;
	logic stickDown;
	logic facingRight;
	logic special;
	logic specialNeutral;

	// Stick thresholds use the top three bits of each axis
	assign stickLeft = controls[stickXHigh:stickXLow] == 3'b000;
	assign stickRight = controls[stickXHigh:stickXLow] == 3'b111;
	assign stickUp = controls[stickYHigh:stickYLow] == 3'b111;
	assign stickDown = controls[stickYHigh:stickYLow] == 3'b000;

	assign facingRight = controls[facingBit];
	assign special = controls[specialBit];

	// Neutral special wants the stick held down, shadowing specialDown
	assign specialNeutral = special && stickDown && !stickLeft && !stickRight && !stickUp;

	always_comb begin
		if (controls[smashLeftBit]) begin
			requestKind = smashLeft;
		end else if (controls[smashRightBit]) begin
			requestKind = smashRight;
		end else if (controls[smashUpBit]) begin
			requestKind = smashUp;
		end else if (controls[smashDownBit]) begin
			requestKind = smashDown;
		end else if (controls[jabBit]) begin
			requestKind = facingRight ? jabRight : jabLeft;
		end else if (specialNeutral) begin
			requestKind = facingRight ? specialNeutralRight : specialNeutralLeft;
		end else if (special && stickLeft) begin
			requestKind = specialLeft;
		end else if (special && stickRight) begin
			requestKind = specialRight;
		end else if (special && stickUp) begin
			requestKind = specialUp;
		end else if (special && stickDown) begin
			requestKind = specialDown;
		end else begin
			requestKind = atkNone;
		end
	end

	// Known words never decode to specialDown or an illegal kind
	always_comb begin
		if (!$isunknown(controls)) begin
			assert final (requestKind inside {[atkNone:specialUp]});
		end
	end

endmodule

/* rtl/attackPkg.sv */
package attackPkg;

	typedef logic [31:0] controlT;
	typedef logic [31:0] attackWordT;

	// Controller word layout
	localparam int smashLeftBit = 23;
	localparam int smashRightBit = 22;
	localparam int smashUpBit = 21;
	localparam int smashDownBit = 20;
	localparam int jabBit = 16;
	localparam int specialBit = 17;
	localparam int facingBit = 26;
	localparam int stickXHigh = 15;
	localparam int stickXLow = 13;
	localparam int stickYHigh = 7;
	localparam int stickYLow = 5;

	// Enum order is also the decode priority
	typedef enum logic [3:0] {
		atkNone,
		smashLeft,
		smashRight,
		smashUp,
		smashDown,
		jabLeft,
		jabRight,
		specialNeutralLeft,
		specialNeutralRight,
		specialLeft,
		specialRight,
		specialUp,
		specialDown
	} attackKindT;

	// Status word layout, bits 31..12 stay zero
	localparam int wordHitFlag = 0;
	localparam int wordSmashUp = 1;
	localparam int wordSmashDown = 2;
	localparam int wordSmashLeft = 3;
	localparam int wordSmashRight = 4;
	localparam int wordJab = 5;
	localparam int wordSpecialUp = 6;
	localparam int wordSpecialDown = 7;
	localparam int wordSpecialLeft = 8;
	localparam int wordSpecialRight = 9;
	localparam int wordSpecialNeutral = 10;
	localparam int wordAnyActive = 11;

	// Knockback vectors as packed X/Y pairs
	localparam logic [31:0] kbUp = 32'h0000_0800;
	localparam logic [31:0] kbDown = 32'h0000_F7FE;
	localparam logic [31:0] kbLeft = 32'hF7FE_00A0;
	localparam logic [31:0] kbRight = 32'h0800_00A0;
	localparam logic [31:0] kbJabLeft = 32'hFFBE_0010;
	localparam logic [31:0] kbJabRight = 32'h0040_0010;
	localparam logic [31:0] kbSpecialNeutralLeft = 32'hFBFE_0080;
	localparam logic [31:0] kbSpecialNeutralRight = 32'h0400_0080;

	localparam logic [31:0] moveSpecialUp = 32'h0000_0010;

endpackage

/* rtl/attackTimer.sv */
`timescale 1ns/10ps

module attackTimer #(
	parameter int smashFrames = 6,
	parameter int jabFrames = 3,
	parameter int specialFrames = 8
) (
	input logic clock,
	input logic arstN,
	input logic frameTaken,
	input attackPkg::attackKindT requestKind,
	output attackPkg::attackKindT activeKind
);
	import attackPkg::*;

	localparam int longFrames = (smashFrames > specialFrames) ? smashFrames : specialFrames;
	localparam int maxFrames = (longFrames > jabFrames) ? longFrames : jabFrames;
	localparam int countW = $clog2(maxFrames + 1);

	typedef logic [countW-1:0] countT;

	typedef enum logic {
		stateIdle,
		stateActive
	} stateT;

	stateT state;
	countT remaining;
	logic attackDone;

	function automatic int durationOf(attackKindT kind);
		case (kind)
			smashLeft, smashRight, smashUp, smashDown: return smashFrames;
			jabLeft, jabRight: return jabFrames;
			default: return specialFrames;
		endcase
	endfunction

	// Last frame of an attack also frees the timer for the next frame
	assign attackDone = (state == stateIdle) || (remaining == '0);

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			state <= stateIdle;
			remaining <= '0;
			activeKind <= atkNone;
		end else if (frameTaken) begin
			if (attackDone) begin
				if (requestKind != atkNone) begin
					state <= stateActive;
					remaining <= countT'(durationOf(requestKind) - 1);
					activeKind <= requestKind;
				end else begin
					state <= stateIdle;
					remaining <= '0;
					activeKind <= atkNone;
				end
			end else begin
				// Requests are ignored here
				remaining <= remaining - 1'b1;
			end
		end
	end

	assert property (@(posedge clock) disable iff (!arstN)
		remaining < countT'(maxFrames));

endmodule

/* rtl/boxCollision.sv */
`timescale 1ns/10ps

module boxCollision (
	input geometryPkg::pointT boxPos,
	input geometryPkg::pointT boxSize,
	input geometryPkg::pointT targetPos,
	input geometryPkg::pointT targetSize,
	output logic hit
);
	import geometryPkg::*;

	coordT boxX;
	coordT boxY;
	coordT boxEndX;
	coordT boxEndY;
	coordT targetX;
	coordT targetY;
	coordT targetEndX;
	coordT targetEndY;
	logic overlapX;
	logic overlapY;

	assign boxX = pointX(boxPos);
	assign boxY = pointY(boxPos);
	assign targetX = pointX(targetPos);
	assign targetY = pointY(targetPos);

	// Far edges wrap like the coordinates
	assign boxEndX = boxX + pointX(boxSize);
	assign boxEndY = boxY + pointY(boxSize);
	assign targetEndX = targetX + pointX(targetSize);
	assign targetEndY = targetY + pointY(targetSize);

	assign overlapX = (boxX < targetEndX) && (targetX < boxEndX);
	assign overlapY = (boxY < targetEndY) && (targetY < boxEndY);
	assign hit = overlapX && overlapY;

endmodule

/* rtl/geometryPkg.sv */
package geometryPkg;

	// One axis value or size, wraps at 16 bits
	typedef logic [15:0] coordT;

	// X in the upper half, Y in the lower half
	typedef logic [31:0] pointT;

	typedef enum logic [1:0] {
		dirLeft,
		dirRight,
		dirUp,
		dirDown
	} boxDirT;

	localparam int numBoxes = 4;

	function automatic coordT pointX(pointT p);
		return p[31:16];
	endfunction

	function automatic coordT pointY(pointT p);
		return p[15:0];
	endfunction

	function automatic pointT makePoint(coordT x, coordT y);
		return {x, y};
	endfunction

endpackage

/* rtl/hitboxGenerator.sv */
`timescale 1ns/10ps

module hitboxGenerator (
	input logic clock,
	input logic arstN,
	input logic frameValid,
	output logic frameReady,
	input geometryPkg::pointT char1Pos,
	input geometryPkg::pointT char1Size,
	input geometryPkg::pointT char2Pos,
	input geometryPkg::pointT char2Size,
	output logic frameTaken,
	output logic boxValid,
	input logic boxReady,
	output geometryPkg::pointT hitPos [geometryPkg::numBoxes],
	output geometryPkg::pointT hitSize,
	output geometryPkg::pointT targetPos,
	output geometryPkg::pointT targetSize
);
	import geometryPkg::*;

	coordT x;
	coordT y;
	coordT width;
	coordT height;
	coordT halfW;
	coordT halfH;
	pointT nextPos [numBoxes];

	assign x = pointX(char1Pos);
	assign y = pointY(char1Pos);
	assign width = pointX(char1Size);
	assign height = pointY(char1Size);
	assign halfW = width >> 1;
	assign halfH = height >> 1;

	always_comb begin
		nextPos[dirLeft] = makePoint(x - halfW, y + (halfH >> 1));
		nextPos[dirRight] = makePoint(x + width, y + (halfH >> 1));
		nextPos[dirUp] = makePoint(x + (halfW >> 1), y + height);
		nextPos[dirDown] = makePoint(x + (halfW >> 1), y - (halfH >> 1));
	end

	assign frameReady = !boxValid || boxReady;
	assign frameTaken = frameValid && frameReady;

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			boxValid <= 1'b0;
		end else if (frameTaken) begin
			boxValid <= 1'b1;
		end else if (boxReady) begin
			boxValid <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (frameTaken) begin
			hitPos <= nextPos;
			hitSize <= makePoint(halfW, halfH);
			targetPos <= char2Pos;
			targetSize <= char2Size;
		end
	end

	// Boxes held while the resolver stalls
	assert property (@(posedge clock) disable iff (!arstN)
		boxValid && !boxReady |=> boxValid && $stable(hitPos[dirLeft])
			&& $stable(hitPos[dirRight]) && $stable(hitPos[dirUp])
			&& $stable(hitPos[dirDown]) && $stable(hitSize)
			&& $stable(targetPos) && $stable(targetSize));

endmodule

/* rtl/strikeResolver.sv */
`timescale 1ns/10ps

module strikeResolver (
	input logic clock,
	input logic arstN,
	input logic boxValid,
	output logic boxReady,
	input logic [geometryPkg::numBoxes-1:0] hit,
	input attackPkg::attackKindT activeKind,
	output logic resultValid,
	input logic resultReady,
	output attackPkg::attackWordT attack,
	output geometryPkg::pointT knockback,
	output geometryPkg::pointT movement
);
	import geometryPkg::*;
	import attackPkg::*;

	boxDirT dir;
	logic boxTaken;
	attackWordT nextAttack;
	pointT nextKnock;
	pointT nextMove;

	// Hitbox that each kind swings through
	always_comb begin
		case (activeKind)
			smashLeft, jabLeft, specialNeutralLeft, specialLeft: dir = dirLeft;
			smashRight, jabRight, specialNeutralRight, specialRight: dir = dirRight;
			smashUp, specialUp: dir = dirUp;
			default: dir = dirDown;
		endcase
	end

	always_comb begin
		nextAttack = '0;
		nextAttack[wordAnyActive] = activeKind != atkNone;
		nextAttack[wordHitFlag] = nextAttack[wordAnyActive] && hit[dir];
		nextAttack[wordSmashUp] = activeKind == smashUp;
		nextAttack[wordSmashDown] = activeKind == smashDown;
		nextAttack[wordSmashLeft] = activeKind == smashLeft;
		nextAttack[wordSmashRight] = activeKind == smashRight;
		nextAttack[wordJab] = activeKind inside {jabLeft, jabRight};
		nextAttack[wordSpecialUp] = activeKind == specialUp;
		nextAttack[wordSpecialDown] = activeKind == specialDown;
		nextAttack[wordSpecialLeft] = activeKind == specialLeft;
		nextAttack[wordSpecialRight] = activeKind == specialRight;
		nextAttack[wordSpecialNeutral] =
			activeKind inside {specialNeutralLeft, specialNeutralRight};
	end

	always_comb begin
		case (activeKind)
			smashUp, specialUp: nextKnock = kbUp;
			smashDown, specialDown: nextKnock = kbDown;
			smashLeft, specialLeft: nextKnock = kbLeft;
			smashRight, specialRight: nextKnock = kbRight;
			jabLeft: nextKnock = kbJabLeft;
			jabRight: nextKnock = kbJabRight;
			specialNeutralLeft: nextKnock = kbSpecialNeutralLeft;
			specialNeutralRight: nextKnock = kbSpecialNeutralRight;
			default: nextKnock = '0;
		endcase
	end

	// Only the up special moves the attacker
	assign nextMove = (activeKind == specialUp) ? moveSpecialUp : '0;

	assign boxReady = !resultValid || resultReady;
	assign boxTaken = boxValid && boxReady;

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			resultValid <= 1'b0;
			attack <= '0;
			knockback <= '0;
			movement <= '0;
		end else if (boxTaken) begin
			resultValid <= 1'b1;
			attack <= nextAttack;
			knockback <= nextKnock;
			movement <= nextMove;
		end else if (resultReady) begin
			resultValid <= 1'b0;
		end
	end

	assert property (@(posedge clock) disable iff (!arstN)
		resultValid && !resultReady |=> resultValid && $stable(attack)
			&& $stable(knockback) && $stable(movement));

endmodule

/* runSim.sh */
#!/bin/sh
# Build the testbench with Verilator, run it, then scan the log for the fail message
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module attackCoprocessorTb -f files.f \
	&& ./obj_dir/VattackCoprocessorTb > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "Build or simulation error"; exit 1; }
cat sim.log
grep -q "Test failed" sim.log && { echo "FAIL"; exit 1; } || { echo "PASS"; exit 0; }

/* testbench/attackCoprocessorTb.sv */
`timescale 1ns/10ps

module attackCoprocessorTb;
	import geometryPkg::*;
	import attackPkg::*;

	localparam int smashLen = 6;
	localparam int jabLen = 3;
	localparam int specialLen = 8;
	localparam int readyTimeout = 200;
	localparam int drainTimeout = 1000;
	localparam int pipeDepth = 2;

	logic clock;
	logic arstN;
	logic frameValid;
	logic frameReady;
	pointT char1Pos;
	pointT char1Size;
	pointT char2Pos;
	pointT char2Size;
	controlT controls;
	logic resultValid;
	logic resultReady;
	attackWordT attack;
	pointT knockback;
	pointT movement;

	// Expected {attack, knockback, movement} per taken frame
	logic [95:0] expectQ [$];
	attackKindT modelKind;
	int modelLeft;
	int errorCount;
	int testErrors;
	int sentCount;
	int resultCount;
	logic stallSink;
	logic [31:0] rng;
	logic [31:0] sinkRng;
	controlT randCtl;
	controlT kindWords [12];
	logic [15:0] boxX [4];
	logic [15:0] boxY [4];
	logic [15:0] span;
	logic [15:0] offset;
	pointT homePos;
	pointT homeSize;
	pointT homeTarget;
	pointT smallSize;

	attackCoprocessor dut_i (
		.clock(clock),
		.arstN(arstN),
		.frameValid(frameValid),
		.frameReady(frameReady),
		.char1Pos(char1Pos),
		.char1Size(char1Size),
		.char2Pos(char2Pos),
		.char2Size(char2Size),
		.controls(controls),
		.resultValid(resultValid),
		.resultReady(resultReady),
		.attack(attack),
		.knockback(knockback),
		.movement(movement)
	);

	always #2 clock = ~clock;

	function automatic logic [31:0] xorshift32(logic [31:0] s);
		s ^= s << 13;
		s ^= s >> 17;
		s ^= s << 5;
		return s;
	endfunction

	function automatic attackKindT decodeKind(controlT ctl);
		logic [2:0] sx;
		logic [2:0] sy;
		sx = ctl[stickXHigh:stickXLow];
		sy = ctl[stickYHigh:stickYLow];
		if (ctl[smashLeftBit]) return smashLeft;
		if (ctl[smashRightBit]) return smashRight;
		if (ctl[smashUpBit]) return smashUp;
		if (ctl[smashDownBit]) return smashDown;
		if (ctl[jabBit]) return ctl[facingBit] ? jabRight : jabLeft;
		if (!ctl[specialBit]) return atkNone;
		// Stick down without a side reads as neutral
		if (sy == 3'b000 && sx != 3'b000 && sx != 3'b111)
			return ctl[facingBit] ? specialNeutralRight : specialNeutralLeft;
		if (sx == 3'b000) return specialLeft;
		if (sx == 3'b111) return specialRight;
		if (sy == 3'b111) return specialUp;
		if (sy == 3'b000) return specialDown;
		return atkNone;
	endfunction

	function automatic int durationFrames(attackKindT kind);
		if (kind inside {smashLeft, smashRight, smashUp, smashDown}) return smashLen;
		if (kind inside {jabLeft, jabRight}) return jabLen;
		return specialLen;
	endfunction

	function automatic logic overlaps(input logic [15:0] ax, ay, aw, ah, bx, by, bw, bh);
		logic [15:0] aEndX;
		logic [15:0] aEndY;
		logic [15:0] bEndX;
		logic [15:0] bEndY;
		aEndX = ax + aw;
		aEndY = ay + ah;
		bEndX = bx + bw;
		bEndY = by + bh;
		return (ax < bEndX) && (bx < aEndX) && (ay < bEndY) && (by < aEndY);
	endfunction

	function automatic logic [95:0] expectResult(attackKindT kind, pointT p1, pointT s1,
			pointT p2, pointT s2);
		logic [15:0] hw;
		logic [15:0] hh;
		logic [15:0] bx;
		logic [15:0] by;
		attackWordT word;
		pointT kb;
		pointT mv;
		int flagBit;
		hw = s1[31:16] >> 1;
		hh = s1[15:0] >> 1;
		bx = p1[31:16] + (hw >> 1);
		by = p1[15:0] - (hh >> 1);
		if (kind inside {smashLeft, jabLeft, specialNeutralLeft, specialLeft}) begin
			bx = p1[31:16] - hw;
			by = p1[15:0] + (hh >> 1);
		end else if (kind inside {smashRight, jabRight, specialNeutralRight, specialRight}) begin
			bx = p1[31:16] + s1[31:16];
			by = p1[15:0] + (hh >> 1);
		end else if (kind inside {smashUp, specialUp}) begin
			by = p1[15:0] + s1[15:0];
		end
		case (kind)
			smashUp: flagBit = wordSmashUp;
			smashDown: flagBit = wordSmashDown;
			smashLeft: flagBit = wordSmashLeft;
			smashRight: flagBit = wordSmashRight;
			jabLeft, jabRight: flagBit = wordJab;
			specialUp: flagBit = wordSpecialUp;
			specialDown: flagBit = wordSpecialDown;
			specialLeft: flagBit = wordSpecialLeft;
			specialRight: flagBit = wordSpecialRight;
			specialNeutralLeft, specialNeutralRight: flagBit = wordSpecialNeutral;
			default: flagBit = -1;
		endcase
		case (kind)
			smashUp, specialUp: kb = kbUp;
			smashDown, specialDown: kb = kbDown;
			smashLeft, specialLeft: kb = kbLeft;
			smashRight, specialRight: kb = kbRight;
			jabLeft: kb = kbJabLeft;
			jabRight: kb = kbJabRight;
			specialNeutralLeft: kb = kbSpecialNeutralLeft;
			specialNeutralRight: kb = kbSpecialNeutralRight;
			default: kb = '0;
		endcase
		mv = (kind == specialUp) ? moveSpecialUp : '0;
		word = '0;
		if (flagBit >= 0) word[flagBit] = 1'b1;
		word[wordAnyActive] = kind != atkNone;
		word[wordHitFlag] = (kind != atkNone)
			&& overlaps(bx, by, hw, hh, p2[31:16], p2[15:0], s2[31:16], s2[15:0]);
		return {word, kb, mv};
	endfunction

	// Timer model steps once per taken frame
	task automatic predictFrame(controlT ctl, pointT p1, pointT s1, pointT p2, pointT s2);
		if (modelLeft == 0) begin
			modelKind = decodeKind(ctl);
			modelLeft = (modelKind == atkNone) ? 0 : durationFrames(modelKind);
		end
		expectQ.push_back(expectResult(modelKind, p1, s1, p2, s2));
		if (modelLeft > 0) modelLeft--;
	endtask

	task automatic abortRun(string why);
		$display("%0t ns: %s", $time, why);
		$display("Test failed");
		$finish;
	endtask

	task automatic sendFrame(controlT ctl, pointT p1, pointT s1, pointT p2, pointT s2);
		int waited;
		@(negedge clock);
		frameValid = 1'b1;
		controls = ctl;
		char1Pos = p1;
		char1Size = s1;
		char2Pos = p2;
		char2Size = s2;
		#1;
		waited = 0;
		while (!frameReady) begin
			if (waited == readyTimeout)
				abortRun("frameReady stayed low, the frame was never taken");
			@(negedge clock);
			#1;
			waited++;
		end
		predictFrame(ctl, p1, s1, p2, s2);
		sentCount++;
		@(posedge clock);
	endtask

	task automatic idleCycle();
		@(negedge clock);
		frameValid = 1'b0;
	endtask

	task automatic drainResults();
		int waited;
		idleCycle();
		waited = 0;
		while (expectQ.size() != 0) begin
			if (waited == drainTimeout) abortRun("results stopped coming out before all frames");
			@(negedge clock);
			waited++;
		end
	endtask

	// A stray result would surface within the pipeline depth
	task automatic settlePipeline();
		repeat (pipeDepth + 1) @(negedge clock);
	endtask

	task automatic reportTest(string name);
		$display("%-26s %s, %0d errors", name, (errorCount == testErrors) ? "ok" : "FAILED",
			errorCount - testErrors);
		testErrors = errorCount;
	endtask

	task automatic compareResult();
		logic [95:0] want;
		resultCount++;
		if (expectQ.size() == 0) begin
			$display("%0t ns: a result came out with no frame waiting for it", $time);
			errorCount++;
		end else begin
			want = expectQ.pop_front();
			if (attack !== want[95:64]) begin
				$display("** Error at %0t ns: attack is %h, expected %h", $time, attack,
					want[95:64]);
				errorCount++;
			end
			if (knockback !== want[63:32]) begin
				$display("** Error at %0t ns: knockback is %h, expected %h", $time, knockback,
					want[63:32]);
				errorCount++;
			end
			if (movement !== want[31:0]) begin
				$display("** Error at %0t ns: movement is %h, expected %h", $time, movement,
					want[31:0]);
				errorCount++;
			end
		end
	endtask

	// Result sink and comparator
	initial begin
		resultReady = 1'b0;
		sinkRng = ~32'd99220;
		forever begin
			@(negedge clock);
			sinkRng = xorshift32(sinkRng);
			resultReady = stallSink ? (sinkRng[3] | sinkRng[9]) : 1'b1;
			#1;
			if (resultValid && resultReady) compareResult();
		end
	end

	initial begin
		clock = 1'b0;
		arstN = 1'b0;
		frameValid = 1'b0;
		controls = '0;
		char1Pos = '0;
		char1Size = '0;
		char2Pos = '0;
		char2Size = '0;
		stallSink = 1'b0;
		rng = 32'd99220;
		modelKind = atkNone;
		modelLeft = 0;
		errorCount = 0;
		testErrors = 0;
		sentCount = 0;
		resultCount = 0;
		homePos = {16'd1000, 16'd1000};
		homeSize = {16'd40, 16'd60};
		// Target sits in the right hitbox only
		homeTarget = {16'd1045, 16'd1020};
		smallSize = {16'd4, 16'd4};
		kindWords = '{32'h00C1_0000, 32'h0060_0000, 32'h0030_0000, 32'h0011_0000,
			32'h0003_0000, 32'h0401_0000, 32'h0002_4000, 32'h0402_4000,
			32'h0002_0040, 32'h0002_E040, 32'h0002_40E0, 32'h0002_0000};
		boxX = '{16'd980, 16'd1040, 16'd1010, 16'd1010};
		boxY = '{16'd1015, 16'd1015, 16'd1060, 16'd985};
		repeat (10) @(posedge clock);
		@(negedge clock);
		arstN = 1'b1;

		#1;
		if (frameReady !== 1'b1) begin
			$display("** Error at %0t ns: frameReady is %b, expected 1", $time, frameReady);
			errorCount++;
		end
		if (resultValid !== 1'b0) begin
			$display("** Error at %0t ns: resultValid is %b, expected 0", $time, resultValid);
			errorCount++;
		end
		sendFrame('0, homePos, homeSize, homeTarget, smallSize);
		drainResults();
		reportTest("reset state");

		for (int i = 0; i < 12; i++) begin
			sendFrame(kindWords[i], homePos, homeSize, homeTarget, smallSize);
			for (int k = 0; k < specialLen; k++) begin
				sendFrame('0, homePos, homeSize, homeTarget, smallSize);
			end
		end
		drainResults();
		reportTest("attack kinds and tables");

		// Jab requests land while the up smash runs
		sendFrame(32'h0020_0000, homePos, homeSize, homeTarget, smallSize);
		for (int k = 1; k < smashLen; k++) begin
			sendFrame(32'h0401_0000, homePos, homeSize, homeTarget, smallSize);
		end
		sendFrame(32'h0002_E040, homePos, homeSize, homeTarget, smallSize);
		for (int k = 0; k < specialLen; k++) begin
			sendFrame('0, homePos, homeSize, homeTarget, smallSize);
		end
		drainResults();
		reportTest("lockout");

		for (int d = 0; d < numBoxes; d++) begin
			span = (d < 2) ? 16'd20 : 16'd30;
			for (int k = 0; k < smashLen; k++) begin
				case (k)
					0: offset = 16'd2;
					1: offset = span - 16'd1;
					2: offset = span;
					3: offset = 16'hFFFC;
					4: offset = 16'hFFFD;
					default: offset = span * 16'd3;
				endcase
				sendFrame((k == 0) ? (32'h0080_0000 >> d) : '0, homePos, homeSize,
					(d < 2) ? {boxX[d] + offset, boxY[d] + 16'd2}
						: {boxX[d] + 16'd2, boxY[d] + offset},
					smallSize);
			end
		end
		drainResults();
		reportTest("hitbox geometry");

		stallSink = 1'b1;
		for (int n = 0; n < 400; n++) begin
			rng = xorshift32(rng);
			if (rng[1:0] == 2'b00) idleCycle();
			randCtl = rng;
			rng = xorshift32(rng);
			randCtl = (randCtl & ~32'h00FF_0000) | (randCtl & rng & 32'h00FF_0000);
			rng = xorshift32(rng);
			sendFrame(randCtl, {rng[31:16], rng[15:0]}, {8'd0, rng[7:0], 8'd0, rng[15:8]},
				{rng[31:16] + rng[23:16] - 16'd96, rng[15:0] + rng[7:0] - 16'd96},
				{8'd0, rng[27:20], 8'd0, rng[19:12]});
		end
		stallSink = 1'b0;
		drainResults();
		settlePipeline();
		if (resultCount != sentCount) begin
			$display("%0t ns: %0d frames were sent but %0d results came out", $time, sentCount,
				resultCount);
			errorCount++;
		end
		reportTest("random with back-pressure");

		$display("Frames %0d, results %0d, errors %0d", sentCount, resultCount, errorCount);
		if (errorCount == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule
